//--- design/riscv_alu_pkg.sv
// *************************************************************************
// Types shared by the RV32IM ALU and the iterative divider: data word,
// shift amount, ALU function codes and the divider step count.
// *************************************************************************

package riscv_alu_pkg;

    typedef logic [31:0] word_t;                // Operand and result word
    typedef logic [4:0]  shamt_t;               // Shift amount, low bits of b

    // *********************************************************************
    // ALU function codes
    // *********************************************************************

    typedef enum logic [4:0] {
        ALU_ZERO   = 5'd0,
        ALU_ADD    = 5'd1,
        ALU_SUB    = 5'd2,
        ALU_SLL    = 5'd3,
        ALU_SRL    = 5'd4,
        ALU_SRA    = 5'd5,
        ALU_SLT    = 5'd6,
        ALU_SLTU   = 5'd7,
        ALU_XOR    = 5'd8,
        ALU_OR     = 5'd9,
        ALU_AND    = 5'd10,
        ALU_MUL    = 5'd11,                     // Low half of signed product
        ALU_MULH   = 5'd12,
        ALU_MULHSU = 5'd13,
        ALU_MULHU  = 5'd14,
        ALU_DIV    = 5'd15,                     // Divide codes go to the divider
        ALU_DIVU   = 5'd16,
        ALU_REM    = 5'd17,
        ALU_REMU   = 5'd18
    } alu_function_t;

    // *********************************************************************
    // Divider
    // *********************************************************************

    localparam int DIV_STEPS = 32;              // One quotient bit per step

endpackage

//--- design/exec_pkg.sv
// *************************************************************************
// Request and response formats of the execute stage channels. A request
// carries a decoded operation, the response returns its result and tag.
// *************************************************************************

package exec_pkg;

    typedef logic [3:0] tag_t;                  // Caller's request identifier

    // Decoded operation, 73 bits
    typedef struct packed {
        riscv_alu_pkg::alu_function_t alu_function;
        riscv_alu_pkg::word_t         operand_a;
        riscv_alu_pkg::word_t         operand_b;
        tag_t                         tag;
    } exec_req_t;

    // Completed operation, 37 bits
    typedef struct packed {
        riscv_alu_pkg::word_t result;
        logic                 result_equal_zero;
        tag_t                 tag;
    } exec_rsp_t;

endpackage

//--- design/alu.sv
// *************************************************************************
// Combinational RV32I and multiply unit. Divide codes return zero, they
// are handled by the iterative divider in the execute stage.
// *************************************************************************

`timescale 1ns/1ps

module alu (
    input  riscv_alu_pkg::alu_function_t alu_function,
    input  riscv_alu_pkg::word_t         operand_a,
    input  riscv_alu_pkg::word_t         operand_b,
    output riscv_alu_pkg::word_t         result,
    output logic                         result_equal_zero
);

    import riscv_alu_pkg::*;

    shamt_t      shamt;
    logic        less_signed;
    logic        less_unsigned;
    logic [63:0] a_sext;
    logic [63:0] b_sext;
    logic [63:0] a_zext;
    logic [63:0] b_zext;
    logic [63:0] signed_multiplication;
    logic [63:0] unsigned_multiplication;
    logic [63:0] signed_unsigned_multiplication;

    assign shamt = operand_b[4:0];              // Upper bits of b ignored

    assign less_signed   = $signed(operand_a) < $signed(operand_b);
    assign less_unsigned = operand_a < operand_b;

    // *********************************************************************
    // 64-bit products, all formed on extended unsigned vectors
    // *********************************************************************

    assign a_sext = {{32{operand_a[31]}}, operand_a};
    assign b_sext = {{32{operand_b[31]}}, operand_b};
    assign a_zext = {32'b0, operand_a};
    assign b_zext = {32'b0, operand_b};

    assign signed_multiplication          = a_sext * b_sext;
    assign unsigned_multiplication        = a_zext * b_zext;
    assign signed_unsigned_multiplication = a_sext * b_zext;

    // *********************************************************************
    // Result select
    // *********************************************************************

    always_comb begin
        result = '0;
        case (alu_function)
            ALU_ZERO:   result = '0;
            ALU_ADD:    result = operand_a + operand_b;
            ALU_SUB:    result = operand_a - operand_b;
            ALU_SLL:    result = operand_a << shamt;
            ALU_SRL:    result = operand_a >> shamt;
            ALU_SRA:    result = word_t'($signed(operand_a) >>> shamt);
            ALU_SLT:    result = {31'b0, less_signed};
            ALU_SLTU:   result = {31'b0, less_unsigned};
            ALU_XOR:    result = operand_a ^ operand_b;
            ALU_OR:     result = operand_a | operand_b;
            ALU_AND:    result = operand_a & operand_b;
            ALU_MUL:    result = signed_multiplication[31:0];
            ALU_MULH:   result = signed_multiplication[63:32];
            ALU_MULHSU: result = signed_unsigned_multiplication[63:32];
            ALU_MULHU:  result = unsigned_multiplication[63:32];
            default:    result = '0;            // Divides and unused codes
        endcase
    end

    assign result_equal_zero = (result == 32'b0);

endmodule

//--- design/serial_divider.sv
// *************************************************************************
// Iterative restoring divider for DIV, DIVU, REM and REMU. A start pulse
// loads the operands; done pulses DIV_STEPS + 1 cycles later and the
// result then holds until the next start.
// *************************************************************************

`timescale 1ns/1ps

module serial_divider (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 start,
    input  riscv_alu_pkg::word_t dividend,
    input  riscv_alu_pkg::word_t divisor,
    input  logic                 is_signed,
    input  logic                 want_remainder,
    output logic                 done,
    output riscv_alu_pkg::word_t quotient_or_remainder
);

    import riscv_alu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } div_state_t;

    typedef logic [$clog2(DIV_STEPS)-1:0] step_t;

    div_state_t  state;
    step_t       step_count;
    logic        dividend_neg;
    logic        divisor_neg;
    word_t       dividend_q;                    // Kept for the special cases
    word_t       divisor_mag;
    word_t       quotient;                      // Shifts the dividend out
    word_t       remainder;
    logic        neg_quotient;
    logic        neg_remainder;
    logic        div_by_zero;
    logic        overflow;
    logic        rem_sel;
    logic [32:0] partial;
    logic        fits;
    word_t       quotient_fix;
    word_t       remainder_fix;

    assign dividend_neg = is_signed & dividend[31];
    assign divisor_neg  = is_signed & divisor[31];

    // One restoring step
    assign partial = {remainder, quotient[31]};
    assign fits    = partial >= {1'b0, divisor_mag};

    // *********************************************************************
    // Control
    // *********************************************************************

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            step_count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= RUN;
                        step_count <= '0;
                    end
                end
                RUN: begin
                    step_count <= step_count + 1'b1;
                    if (step_count == step_t'(DIV_STEPS - 1)) begin
                        state <= FIX;           // Last quotient bit this edge
                    end
                end
                FIX:     state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // *********************************************************************
    // Datapath
    // *********************************************************************

    always_ff @(posedge clock) begin
        if (state == IDLE && start) begin
            dividend_q    <= dividend;
            divisor_mag   <= divisor_neg ? -divisor : divisor;
            quotient      <= dividend_neg ? -dividend : dividend;
            remainder     <= '0;
            neg_quotient  <= dividend_neg ^ divisor_neg;
            neg_remainder <= dividend_neg;      // Remainder takes dividend sign
            div_by_zero   <= (divisor == 32'b0);
            overflow      <= is_signed && (dividend == 32'h8000_0000)
                             && (divisor == 32'hffff_ffff);
            rem_sel       <= want_remainder;
        end else if (state == RUN) begin
            remainder <= fits ? word_t'(partial - {1'b0, divisor_mag}) : partial[31:0];
            quotient  <= {quotient[30:0], fits};
        end
    end

    assign quotient_fix  = neg_quotient  ? -quotient  : quotient;
    assign remainder_fix = neg_remainder ? -remainder : remainder;

    always_comb begin
        if (div_by_zero) begin
            quotient_or_remainder = rem_sel ? dividend_q : 32'hffff_ffff;
        end else if (overflow) begin
            quotient_or_remainder = rem_sel ? 32'b0 : dividend_q;
        end else begin
            quotient_or_remainder = rem_sel ? remainder_fix : quotient_fix;
        end
    end

    assign done = (state == FIX);

endmodule

//--- design/execute_unit.sv
// *************************************************************************
// Execute stage of a small RV32IM core. Takes decoded operations on a
// valid/ready request channel and returns results with their tags on a
// valid/ready response channel, one ALU operation per cycle.
// *************************************************************************

`timescale 1ns/1ps

module execute_unit (
    input  logic                clock,
    input  logic                arst_n,
    input  exec_pkg::exec_req_t req,
    input  logic                req_valid,
    output logic                req_ready,
    output exec_pkg::exec_rsp_t rsp,
    output logic                rsp_valid,
    input  logic                rsp_ready
);

    import riscv_alu_pkg::*;
    import exec_pkg::*;

    typedef enum logic {
        IDLE,
        WAIT_DIV
    } exec_state_t;

    exec_state_t state;
    logic        accept;
    logic        is_div;
    logic        div_signed;
    logic        div_want_rem;
    logic        slot_free;
    logic        alu_load;
    logic        div_load;
    logic        div_start;
    logic        div_done;
    word_t       alu_result;
    logic        alu_zero;
    word_t       div_result;
    tag_t        div_tag;

    // *********************************************************************
    // Request dispatch
    // *********************************************************************

    assign is_div       = req.alu_function inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign div_signed   = req.alu_function inside {ALU_DIV, ALU_REM};
    assign div_want_rem = req.alu_function inside {ALU_REM, ALU_REMU};

    assign slot_free = !rsp_valid || rsp_ready;
    assign req_ready = (state == IDLE) && slot_free;
    assign accept    = req_valid && req_ready;

    assign alu_load  = accept && !is_div;
    assign div_start = accept && is_div;        // Divider samples on this edge
    assign div_load  = (state == WAIT_DIV) && div_done;

    alu alu_i (
        .alu_function      (req.alu_function),
        .operand_a         (req.operand_a),
        .operand_b         (req.operand_b),
        .result            (alu_result),
        .result_equal_zero (alu_zero)
    );

    serial_divider divider_i (
        .clock                 (clock),
        .arst_n                (arst_n),
        .start                 (div_start),
        .dividend              (req.operand_a),
        .divisor               (req.operand_b),
        .is_signed             (div_signed),
        .want_remainder        (div_want_rem),
        .done                  (div_done),
        .quotient_or_remainder (div_result)
    );

    // *********************************************************************
    // Divide sequencing and response slot
    // *********************************************************************

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE:     if (div_start) state <= WAIT_DIV;
                WAIT_DIV: if (div_load) state <= IDLE;
            endcase

            if (alu_load || div_load) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (div_start) begin
            div_tag <= req.tag;
        end
        if (alu_load) begin
            rsp <= '{result: alu_result, result_equal_zero: alu_zero, tag: req.tag};
        end else if (div_load) begin
            rsp <= '{result: div_result, result_equal_zero: (div_result == 32'b0),
                     tag: div_tag};
        end
    end

endmodule

//--- dv/execute_unit_checker.sv
// *************************************************************************
// Concurrent assertions on the execute stage: response hold under
// back-pressure, request stall during a divide, fixed divider latency.
// *************************************************************************

`timescale 1ns/1ps

module execute_unit_checker (
    input logic                clock,
    input logic                arst_n,
    input logic                req_ready,
    input exec_pkg::exec_rsp_t rsp,
    input logic                rsp_valid,
    input logic                rsp_ready,
    input logic                div_start,
    input logic                div_done
);

    import riscv_alu_pkg::*;

    logic div_busy;
    int   since_start;                          // Cycles since the start pulse

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            div_busy    <= 1'b0;
            since_start <= 0;
        end else if (div_start) begin
            div_busy    <= 1'b1;
            since_start <= 1;
        end else if (div_done) begin
            div_busy <= 1'b0;
        end else if (div_busy) begin
            since_start <= since_start + 1;
        end
    end

    rsp_held: assert property (@(posedge clock) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed or withdrawn while the sink stalled");

    no_req_while_dividing: assert property (@(posedge clock) disable iff (!arst_n)
        div_busy |-> !req_ready)
        else $error("request channel ready while the divider is busy");

    div_latency: assert property (@(posedge clock) disable iff (!arst_n)
        div_done == (div_busy && since_start == DIV_STEPS + 1))
        else $error("divider done pulse not exactly DIV_STEPS + 1 cycles after start");

endmodule

bind execute_unit execute_unit_checker checker_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .div_start (div_start),
    .div_done  (div_done)
);

//--- dv/execute_unit_tb.sv
// *************************************************************************
// Testbench for the execute stage. Applies a table of directed and random
// operations, models the expected results and checks every response in
// issue order while the response sink stalls at random.
// *************************************************************************

`timescale 1ns/1ps

module execute_unit_tb;

    import riscv_alu_pkg::*;
    import exec_pkg::*;

    localparam int CLOCK_PERIOD     = 100;
    localparam int RESET_CYCLES     = 16;
    localparam int NUM_DIRECTED     = 30;
    localparam int NUM_RANDOM       = 40;
    localparam int NUM_ENTRIES      = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + NUM_ENTRIES * 40 + 200;

    logic      clock;
    logic      arst_n;
    exec_req_t req;
    logic      req_valid;
    logic      req_ready;
    exec_rsp_t rsp;
    logic      rsp_valid;
    logic      rsp_ready;

    string         names[NUM_ENTRIES];
    alu_function_t funcs[NUM_ENTRIES];
    word_t         op_a[NUM_ENTRIES];
    word_t         op_b[NUM_ENTRIES];
    word_t         expected[NUM_ENTRIES];
    int            entry_count = 0;
    int            exp_idx_q[$];                // Issue order
    tag_t          exp_tag_q[$];
    tag_t          next_tag = '0;
    int            seed = 32'had80;
    int            hold_low = 0;
    int            checked = 0;
    int            value_errors = 0;
    int            other_errors = 0;

    execute_unit dut_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // *********************************************************************
    // Reference model and table
    // *********************************************************************

    function automatic word_t model_result(input alu_function_t f, input word_t a,
                                           input word_t b);
        longint      sa;
        longint      sb;
        longint      ua;
        longint      ub;
        logic [63:0] prod;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = longint'({32'b0, a});
        ub = longint'({32'b0, b});
        case (f)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_SLL:    return a << b[4:0];
            ALU_SRL:    return a >> b[4:0];
            ALU_SRA:    return word_t'(sa >>> b[4:0]);
            ALU_SLT:    return (sa < sb) ? 32'd1 : 32'd0;
            ALU_SLTU:   return (ua < ub) ? 32'd1 : 32'd0;
            ALU_XOR:    return a ^ b;
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_MUL: begin
                prod = sa * sb;
                return prod[31:0];
            end
            ALU_MULH: begin
                prod = sa * sb;
                return prod[63:32];
            end
            ALU_MULHSU: begin
                prod = sa * ub;
                return prod[63:32];
            end
            ALU_MULHU: begin
                prod = ua * ub;
                return prod[63:32];
            end
            ALU_DIV: begin
                if (b == 32'b0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
                return word_t'(sa / sb);        // Truncates toward zero
            end
            ALU_DIVU:   return (b == 32'b0) ? 32'hffff_ffff : word_t'(ua / ub);
            ALU_REM: begin
                if (b == 32'b0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'b0;
                return word_t'(sa % sb);        // Sign of the dividend
            end
            ALU_REMU:   return (b == 32'b0) ? a : word_t'(ua % ub);
            default:    return 32'b0;
        endcase
    endfunction

    task automatic add_entry(input string name, input alu_function_t func, input word_t a,
                             input word_t b, input word_t result);
        names[entry_count]    = name;
        funcs[entry_count]    = func;
        op_a[entry_count]     = a;
        op_b[entry_count]     = b;
        expected[entry_count] = result;
        entry_count++;
    endtask

    task automatic build_table();
        alu_function_t func;
        word_t         a;
        word_t         b;
        add_entry("add_basic",         ALU_ADD,    32'd5,         32'd7,         32'd12);
        add_entry("add_wrap_zero",     ALU_ADD,    32'hffffffff,  32'd1,         32'd0);
        add_entry("sub_negative",      ALU_SUB,    32'd3,         32'd5,         32'hfffffffe);
        add_entry("sll_low_bits",      ALU_SLL,    32'd1,         32'h24,        32'h10);
        add_entry("srl_low_bits",      ALU_SRL,    32'h80000000,  32'hffffffff,  32'd1);
        add_entry("sra_negative",      ALU_SRA,    32'h80000000,  32'd4,         32'hf8000000);
        add_entry("slt_mixed",         ALU_SLT,    32'hffffffff,  32'd1,         32'd1);
        add_entry("sltu_mixed",        ALU_SLTU,   32'hffffffff,  32'd1,         32'd0);
        add_entry("xor_pattern",       ALU_XOR,    32'hf0f0f0f0,  32'hffff0000,  32'h0f0ff0f0);
        add_entry("or_halves",         ALU_OR,     32'h12340000,  32'h00005678,  32'h12345678);
        add_entry("and_pattern",       ALU_AND,    32'hf0f0f0f0,  32'h0ff00ff0,  32'h00f000f0);
        add_entry("alu_zero",          ALU_ZERO,   32'h1234,      32'h5678,      32'd0);
        add_entry("mul_negative",      ALU_MUL,    32'hfffffffe,  32'd3,         32'hfffffffa);
        add_entry("mulh_min_min",      ALU_MULH,   32'h80000000,  32'h80000000,  32'h40000000);
        add_entry("mulh_min_one",      ALU_MULH,   32'h80000000,  32'd1,         32'hffffffff);
        add_entry("mulhsu_neg_max",    ALU_MULHSU, 32'hffffffff,  32'hffffffff,  32'hffffffff);
        add_entry("mulhsu_min_max",    ALU_MULHSU, 32'h80000000,  32'hffffffff,  32'h80000000);
        add_entry("mulhu_max_max",     ALU_MULHU,  32'hffffffff,  32'hffffffff,  32'hfffffffe);
        add_entry("div_negative",      ALU_DIV,    32'hfffffff9,  32'd2,         32'hfffffffd);
        add_entry("rem_negative",      ALU_REM,    32'hfffffff9,  32'd2,         32'hffffffff);
        add_entry("divu_large",        ALU_DIVU,   32'hffffffff,  32'd2,         32'h7fffffff);
        add_entry("remu_small",        ALU_REMU,   32'd100,       32'd7,         32'd2);
        add_entry("div_by_zero",       ALU_DIV,    32'h1234,      32'd0,         32'hffffffff);
        add_entry("divu_by_zero",      ALU_DIVU,   32'h1234,      32'd0,         32'hffffffff);
        add_entry("rem_by_zero",       ALU_REM,    32'h1234,      32'd0,         32'h1234);
        add_entry("remu_by_zero",      ALU_REMU,   32'hffff0000,  32'd0,         32'hffff0000);
        add_entry("div_overflow",      ALU_DIV,    32'h80000000,  32'hffffffff,  32'h80000000);
        add_entry("rem_overflow",      ALU_REM,    32'h80000000,  32'hffffffff,  32'd0);
        add_entry("divu_min_neg_one",  ALU_DIVU,   32'h80000000,  32'hffffffff,  32'd0);
        add_entry("div_zero_quotient", ALU_DIV,    32'd3,         32'd7,         32'd0);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (n % 2 == 1) begin                // Every other one a divide
                func = alu_function_t'(5'(ALU_DIV) + 5'({$random(seed)} % 4));
            end else begin
                func = alu_function_t'(5'({$random(seed)} % 19));
            end
            a = $random(seed);
            b = word_t'($random(seed)) >> ({$random(seed)} % 32);
            add_entry($sformatf("random_%0d_%s", n, func.name()), func, a, b,
                      model_result(func, a, b));
        end
    endtask

    // *********************************************************************
    // Request side
    // *********************************************************************

    task automatic issue_entry(input int idx);
        logic accepted;
        @(negedge clock);
        req.alu_function = funcs[idx];
        req.operand_a    = op_a[idx];
        req.operand_b    = op_b[idx];
        req.tag          = next_tag;
        req_valid        = 1'b1;
        accepted         = 1'b0;
        while (!accepted) begin
            #1;                                 // Ready settles after the negedge drives
            accepted = req_ready;
            if (!accepted) @(negedge clock);
        end
        exp_idx_q.push_back(idx);
        exp_tag_q.push_back(next_tag);
        next_tag = next_tag + 1'b1;
        @(posedge clock);
    endtask

    // *********************************************************************
    // Response side
    // *********************************************************************

    task automatic drive_rsp_ready();
        if (hold_low == 0 && ({$random(seed)} % 6) == 0) begin
            hold_low = 1 + ({$random(seed)} % 10);
        end
        if (hold_low > 0) begin
            rsp_ready = 1'b0;
            hold_low--;
        end else begin
            rsp_ready = 1'b1;
        end
    endtask

    task automatic check_response();
        int   idx;
        tag_t exp_tag;
        assert (exp_idx_q.size() > 0) else begin
            other_errors++;
            $display("Response with tag %0d arrived with no request pending", rsp.tag);
        end
        if (exp_idx_q.size() > 0) begin
            idx     = exp_idx_q.pop_front();
            exp_tag = exp_tag_q.pop_front();
            checked++;
            assert (rsp.result == expected[idx]) else begin
                value_errors++;
                $display("[FAIL] %s result: expected %h, actual %h", names[idx],
                         expected[idx], rsp.result);
            end
            assert (rsp.result_equal_zero == (expected[idx] == 32'b0)) else begin
                value_errors++;
                $display("[FAIL] %s zero flag: expected %0b, actual %0b", names[idx],
                         expected[idx] == 32'b0, rsp.result_equal_zero);
            end
            assert (rsp.tag == exp_tag) else begin
                value_errors++;
                $display("[FAIL] %s tag: expected %0d, actual %0d", names[idx], exp_tag,
                         rsp.tag);
            end
        end
    endtask

    // Sampled ahead of the transfer edge while rsp is stable
    always @(negedge clock) begin
        if (arst_n) begin
            drive_rsp_ready();
            if (rsp_valid && rsp_ready) check_response();
        end
    end

    // *********************************************************************
    // Main sequence and watchdog
    // *********************************************************************

    initial begin
        clock     = 1'b0;
        arst_n    = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clock);
        arst_n <= 1'b1;
        #1;
        assert (!rsp_valid) else begin
            value_errors++;
            $display("[FAIL] after_reset rsp_valid: expected 0, actual %0b", rsp_valid);
        end
        assert (req_ready) else begin
            value_errors++;
            $display("[FAIL] after_reset req_ready: expected 1, actual %0b", req_ready);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            issue_entry(i);
        end
        @(negedge clock);
        req_valid = 1'b0;
        wait (checked == NUM_ENTRIES);
        repeat (8) @(negedge clock);            // Catch stray extra responses
        $display("Checked %0d of %0d responses, %0d value errors, %0d other errors",
                 checked, NUM_ENTRIES, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: only %0d of %0d responses arrived in time", checked, NUM_ENTRIES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- execute_unit.f
design/riscv_alu_pkg.sv
design/exec_pkg.sv
design/alu.sv
design/serial_divider.sv
design/execute_unit.sv
dv/execute_unit_checker.sv
dv/execute_unit_tb.sv

//--- Makefile
TOP := execute_unit_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f execute_unit.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation finished cleanly"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f execute_unit.f \
		--top-module execute_unit

clean:
	rm -rf obj_dir $(LOG)
